//--- tb.f
design/scrmbl_pkg.sv
design/present_round.sv
design/scrmbl_sequencer.sv
design/scrmbl_state_regs.sv
design/scrmbl_top.sv
verification/scrmbl_checker.sv
verification/scrmbl_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= scrmbl_tb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
RUNFLAGS  ?= +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- verification/scrmbl_tb.sv
/*
  Testbench for the scrambling engine. Runs the known-answer vector,
  random encryptions, standard and chained digests and an interleaved
  sequence against a PRESENT-128 reference model.
*/

`timescale 1ns/10ps

module scrmbl_tb;

  import scrmbl_pkg::*;

  // the KAT plus 31 more ciphering commands below
  localparam int          num_cipher_cmds = 32;
  localparam int          timeout_cycles  = 40 * num_cipher_cmds + 100;
  localparam logic [63:0] kat_result      = 64'h96db702a2e6900af;
  // PRESENT sbox with entry 0 in the top nibble
  localparam logic [63:0] sbox_row        = 64'hc56b90ad3ef84712;

  logic                   clk_i;
  logic                   rst_ni;
  scrmbl_req_t            req_i;
  logic                   valid_i;
  logic                   ready_o;
  logic [block_width-1:0] data_o;
  logic                   valid_o;

  logic [31:0] lfsr      = 32'h8ec2;
  int          err_cnt   = 0;
  int          acc_cnt   = 0;
  int          pulse_cnt = 0;
  int          cycle_cnt = 0;

  scrmbl_top uut (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_o  (data_o),
    .valid_o (valid_o)
  );

  bind scrmbl_top scrmbl_checker u_checker (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_o  (data_o),
    .valid_o (valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // watchdog
  initial begin
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  // count accepted ciphering commands and output pulses
  always @(negedge clk_i) begin
    if (rst_ni && valid_i && ready_o &&
        (req_i.cmd inside {cmd_encrypt, cmd_digest, cmd_digest_final})) begin
      acc_cnt++;
    end
    if (valid_o) begin
      pulse_cnt++;
    end
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [3:0] sbox_nib(input logic [3:0] x);
    return sbox_row[63 - 4 * int'(x) -: 4];
  endfunction

  // PRESENT-128 with 31 rounds then output whitening
  function automatic logic [63:0] present_enc(input logic [63:0] pt, input logic [127:0] key);
    logic [63:0]  st;
    logic [63:0]  perm;
    logic [127:0] k;
    st = pt;
    k  = key;
    for (int r = 1; r <= 31; r++) begin
      st = st ^ k[127:64];
      for (int n = 0; n < 16; n++) begin
        st[4*n +: 4] = sbox_nib(st[4*n +: 4]);
      end
      // bit b lands on 16*(b mod 4) + b/4
      for (int b = 0; b < 64; b++) begin
        perm[16 * (b % 4) + b / 4] = st[b];
      end
      st         = perm;
      k          = {k[66:0], k[127:67]};
      k[127:124] = sbox_nib(k[127:124]);
      k[123:120] = sbox_nib(k[123:120]);
      k[66:62]   = k[66:62] ^ r[4:0];
    end
    return st ^ k[127:64];
  endfunction

  // Davies-Meyer compression
  function automatic logic [63:0] dm_step(input logic [63:0] state, input logic [127:0] key);
    return present_enc(state, key) ^ state;
  endfunction

  // fibonacci LFSR x^32+x^22+x^2+x+1 stepped once per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // drivers and checks
  ////////////////////////////////////////

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
    else begin
      err_cnt++;
      $display("Error: %s expected %h, got %h", name, exp, act);
    end
  endtask

  // waits for ready and holds valid_i over one accepting edge
  task automatic drive_req(input scrmbl_cmd_e cmd, input digest_mode_e mode,
                           input logic [1:0] sel, input logic [63:0] data);
    while (!ready_o) begin
      @(posedge clk_i);
      #2;
    end
    req_i.cmd  = cmd;
    req_i.mode = mode;
    req_i.sel  = sel;
    req_i.data = data;
    valid_i    = 1'b1;
    @(posedge clk_i);
    #2;
    valid_i = 1'b0;
  endtask

  task automatic run_cipher(input scrmbl_cmd_e cmd, input logic [1:0] sel,
                            input logic [63:0] data, input bit poke,
                            output logic [63:0] res);
    drive_req(cmd, mode_standard, sel, data);
    // a request while busy must be dropped
    if (poke) begin
      req_i.cmd  = cmd_digest_final;
      req_i.sel  = ~sel;
      req_i.data = ~data;
      valid_i    = 1'b1;
      repeat (4) @(posedge clk_i);
      #2;
      valid_i = 1'b0;
    end
    while (!valid_o) begin
      @(posedge clk_i);
      #2;
    end
    res = data_o;
  endtask

  task automatic encrypt_check(input logic [63:0] blk, input logic [1:0] sel,
                               input bit poke, output logic [63:0] res);
    run_cipher(cmd_encrypt, sel, blk, poke, res);
    check_val("data_o", present_enc(blk, scrmbl_key_tbl[sel]), res);
  endtask

  // standard mode update where lo goes through the shadow register
  task automatic digest_update(inout logic [63:0] state, input bit poke);
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] res;
    lo = rand_bits(64);
    hi = rand_bits(64);
    drive_req(cmd_load_shadow, mode_standard, 2'd0, lo);
    // shadow load takes effect at once and leaves the engine idle
    check_val("ready_o", 64'd1, 64'(ready_o));
    run_cipher(cmd_digest, 2'd0, hi, poke, res);
    state = dm_step(state, {hi, lo});
    check_val("data_o", state, res);
  endtask

  task automatic digest_final(inout logic [63:0] state, input logic set);
    logic [63:0] res;
    run_cipher(cmd_digest_final, {1'b0, set}, rand_bits(64), 1'b0, res);
    state = dm_step(state, digest_const_tbl[set]);
    check_val("data_o", state, res);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    logic [63:0] res;
    logic [63:0] blk;
    logic [63:0] a_enc;
    logic [63:0] b_enc;
    logic [63:0] state;
    logic [1:0]  sel;

    rst_ni  = 1'b0;
    valid_i = 1'b0;
    req_i   = '0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // idle outputs after reset
    check_val("ready_o", 64'd1, 64'(ready_o));
    check_val("valid_o", 64'd0, 64'(valid_o));
    check_val("data_o", 64'd0, data_o);

    // known answer for a zero block under the zero key
    check_val("present_enc", kat_result, present_enc(64'd0, 128'd0));
    run_cipher(cmd_encrypt, 2'd0, 64'd0, 1'b0, res);
    check_val("data_o", kat_result, res);

    repeat (20) begin
      blk = rand_bits(64);
      sel = 2'(rand_bits(2));
      encrypt_check(blk, sel, 1'b0, res);
    end

    // standard digest with set 1
    drive_req(cmd_digest_init, mode_standard, 2'd1, 64'd0);
    state = digest_iv_tbl[1];
    repeat (2) digest_update(state, 1'b0);
    digest_final(state, 1'b1);

    // chained digest over the message {enc b, enc a}
    drive_req(cmd_digest_init, mode_chained, 2'd0, 64'd0);
    state = digest_iv_tbl[0];
    blk   = rand_bits(64);
    sel   = 2'(rand_bits(2));
    encrypt_check(blk, sel, 1'b0, a_enc);
    // input word is unused in chained mode
    drive_req(cmd_load_shadow, mode_standard, 2'd0, rand_bits(64));
    blk = rand_bits(64);
    sel = 2'(rand_bits(2));
    encrypt_check(blk, sel, 1'b0, b_enc);
    run_cipher(cmd_digest, 2'd0, rand_bits(64), 1'b0, res);
    state = dm_step(state, {b_enc, a_enc});
    check_val("data_o", state, res);
    digest_final(state, 1'b0);

    // encrypt between updates with busy requests thrown in
    drive_req(cmd_digest_init, mode_standard, 2'd0, 64'd0);
    state = digest_iv_tbl[0];
    digest_update(state, 1'b1);
    blk = rand_bits(64);
    sel = 2'(rand_bits(2));
    encrypt_check(blk, sel, 1'b1, res);
    digest_update(state, 1'b0);
    digest_final(state, 1'b0);

    repeat (2) @(posedge clk_i);
    #2;
    check_val("acc_cnt", 64'(num_cipher_cmds), 64'(acc_cnt));
    check_val("pulse_cnt", 64'(acc_cnt), 64'(pulse_cnt));

    $display("errors: %0d value checks, %0d protocol assertions",
             err_cnt, uut.u_checker.fail_cnt);
    if (err_cnt == 0 && uut.u_checker.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verification/scrmbl_checker.sv
/*
  Protocol checks for the scrambling engine, bound into the top level.
  Watches the request handshake and the timing of the output pulse.
*/

`timescale 1ns/10ps

module scrmbl_checker (
  input logic                               clk_i,
  input logic                               rst_ni,
  input scrmbl_pkg::scrmbl_req_t            req_i,
  input logic                               valid_i,
  input logic                               ready_o,
  input logic [scrmbl_pkg::block_width-1:0] data_o,
  input logic                               valid_o
);

  import scrmbl_pkg::*;

  // accept edge plus all rounds
  localparam int unsigned result_lat = num_rounds + 1;

  logic       cipher_acc;
  logic [5:0] since_acc;
  int         fail_cnt = 0;

  // the three commands that run the round loop
  assign cipher_acc = valid_i && ready_o &&
                      (req_i.cmd inside {cmd_encrypt, cmd_digest, cmd_digest_final});

  // edges since the last accepted ciphering command, 0 when nothing runs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      since_acc <= '0;
    end else if (cipher_acc) begin
      since_acc <= 6'd1;
    end else if (since_acc != '0 && since_acc != 6'(result_lat)) begin
      since_acc <= since_acc + 6'd1;
    end else begin
      since_acc <= '0;
    end
  end

  ////////////////////////////////////////
  // output pulse
  ////////////////////////////////////////

  single_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |=> !valid_o)
    else begin
      $error("valid_o stayed high for two cycles");
      fail_cnt++;
    end

  // output bus is quiet between results
  data_gate_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !valid_o |-> data_o == '0)
    else begin
      $error("data_o not zero while valid_o is low");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // handshake and latency
  ////////////////////////////////////////

  busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (since_acc != '0 && since_acc < 6'(result_lat)) |-> !ready_o)
    else begin
      $error("ready_o high while a ciphering command runs");
      fail_cnt++;
    end

  // pulse comes exactly 32 edges after acceptance, and never otherwise
  latency_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o == (since_acc == 6'(result_lat)))
    else begin
      $error("valid_o not 32 edges after an accepted ciphering command");
      fail_cnt++;
    end

endmodule

//--- design/scrmbl_top.sv
/*
  Top level of the scrambling engine. Connects the sequencer, the
  PRESENT round and the state registers; no logic of its own.
*/

`timescale 1ns/10ps

module scrmbl_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  scrmbl_pkg::scrmbl_req_t            req_i,
  input  logic                               valid_i,
  output logic                               ready_o,
  output logic [scrmbl_pkg::block_width-1:0] data_o,
  output logic                               valid_o
);

  import scrmbl_pkg::*;

  reg_ctrl_t              ctrl;
  logic [block_width-1:0] data_q, rnd_data;
  key_msg_u               key_q, rnd_key;
  logic [cnt_width-1:0]   idx_q, rnd_idx;

  // input side
  scrmbl_sequencer u_sequencer (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (req_i.cmd),
    .mode_i  (req_i.mode),
    .valid_i (valid_i),
    .idx_i   (idx_q),
    .ready_o (ready_o),
    .ctrl_o  (ctrl)
  );

  // one cipher round per cycle
  present_round u_round (
    .data_i (data_q),
    .key_i  (key_q),
    .idx_i  (idx_q),
    .data_o (rnd_data),
    .key_o  (rnd_key),
    .idx_o  (rnd_idx)
  );

  // output side
  scrmbl_state_regs u_state_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ctrl_i     (ctrl),
    .sel_i      (req_i.sel),
    .data_i     (req_i.data),
    .rnd_data_i (rnd_data),
    .rnd_key_i  (rnd_key),
    .rnd_idx_i  (rnd_idx),
    .data_q_o   (data_q),
    .key_q_o    (key_q),
    .idx_q_o    (idx_q),
    .data_o     (data_o),
    .valid_o    (valid_o)
  );

endmodule

//--- design/scrmbl_state_regs.sv
/*
  Working registers of the scrambling engine: key, round index, data,
  shadow and digest state, plus the registered output valid. Next
  values are picked by the controls coming from the sequencer.
*/

`timescale 1ns/10ps

module scrmbl_state_regs (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  scrmbl_pkg::reg_ctrl_t              ctrl_i,
  input  logic [scrmbl_pkg::sel_width-1:0]   sel_i,
  input  logic [scrmbl_pkg::block_width-1:0] data_i,
  input  logic [scrmbl_pkg::block_width-1:0] rnd_data_i,
  input  scrmbl_pkg::key_msg_u               rnd_key_i,
  input  logic [scrmbl_pkg::cnt_width-1:0]   rnd_idx_i,
  output logic [scrmbl_pkg::block_width-1:0] data_q_o,
  output scrmbl_pkg::key_msg_u               key_q_o,
  output logic [scrmbl_pkg::cnt_width-1:0]   idx_q_o,
  output logic [scrmbl_pkg::block_width-1:0] data_o,
  output logic                               valid_o
);

  import scrmbl_pkg::*;

  key_msg_u               key_d, key_q;
  logic [cnt_width-1:0]   idx_d, idx_q;
  logic [block_width-1:0] data_d, data_q;
  logic [block_width-1:0] shadow_q;
  logic [block_width-1:0] digest_d, digest_q;
  logic [block_width-1:0] rnd_xor;
  logic                   valid_q;

  ////////////////////////////////////////
  // next-value muxes
  ////////////////////////////////////////

  // Davies-Meyer feed-forward
  assign rnd_xor = rnd_data_i ^ digest_q;

  always_comb begin
    case (ctrl_i.data_sel)
      data_sel_round:     data_d = rnd_data_i;
      data_sel_digest:    data_d = digest_q;
      data_sel_round_xor: data_d = rnd_xor;
      default:            data_d = data_i;
    endcase
  end

  always_comb begin
    case (ctrl_i.key_sel)
      key_sel_table: key_d.key = scrmbl_key_tbl[sel_i];
      key_sel_const: key_d.key = digest_const_tbl[sel_i[$clog2(num_digest_sets)-1:0]];
      key_sel_msg_input: begin
        // standard mode, {input, shadow}
        key_d.msg.hi = data_i;
        key_d.msg.lo = shadow_q;
      end
      key_sel_msg_chained: begin
        // chained mode, {last result, shadow}
        key_d.msg.hi = data_q;
        key_d.msg.lo = shadow_q;
      end
      default: key_d = rnd_key_i;
    endcase
  end

  // round index restarts at 1 on every fresh key load
  assign idx_d = (ctrl_i.key_sel == key_sel_round) ? rnd_idx_i : cnt_width'(1);

  assign digest_d = ctrl_i.digest_init ? digest_iv_tbl[sel_i[$clog2(num_digest_sets)-1:0]]
                                       : rnd_xor;

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q    <= '0;
      idx_q    <= '0;
      data_q   <= '0;
      shadow_q <= '0;
      digest_q <= '0;
      valid_q  <= 1'b0;
    end else begin
      valid_q <= ctrl_i.valid_d;
      if (ctrl_i.key_en) begin
        key_q <= key_d;
        idx_q <= idx_d;
      end
      if (ctrl_i.data_en) begin
        data_q <= data_d;
      end
      // copy wins over load, the sequencer never raises both
      if (ctrl_i.shadow_copy) begin
        shadow_q <= data_q;
      end else if (ctrl_i.shadow_load) begin
        shadow_q <= data_i;
      end
      if (ctrl_i.digest_en) begin
        digest_q <= digest_d;
      end
    end
  end

  assign data_q_o = data_q;
  assign key_q_o  = key_q;
  assign idx_q_o  = idx_q;

  // output only shows the data state during the valid pulse
  assign valid_o = valid_q;
  assign data_o  = valid_q ? data_q : '0;

endmodule

//--- design/scrmbl_sequencer.sv
/*
  Command decoder and round sequencer. Accepts one request at a time
  through the valid/ready handshake and steers the register muxes.
  The round index held in the state registers doubles as the counter.
*/

`timescale 1ns/10ps

module scrmbl_sequencer (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  scrmbl_pkg::scrmbl_cmd_e          cmd_i,
  input  scrmbl_pkg::digest_mode_e         mode_i,
  input  logic                             valid_i,
  input  logic [scrmbl_pkg::cnt_width-1:0] idx_i,
  output logic                             ready_o,
  output scrmbl_pkg::reg_ctrl_t            ctrl_o
);

  import scrmbl_pkg::*;

  seq_state_e   state_d, state_q;
  digest_mode_e mode_d, mode_q;
  logic         last_rnd;

  // index register holds the round about to be computed
  assign last_rnd = (idx_i == cnt_width'(num_rounds));

  always_comb begin
    state_d          = state_q;
    mode_d           = mode_q;
    ready_o          = 1'b0;
    ctrl_o           = '0;
    ctrl_o.data_sel  = data_sel_input;
    ctrl_o.key_sel   = key_sel_table;

    case (state_q)
      ////////////////////////////////////////
      // idle: decode and load working regs
      st_idle: begin
        ready_o = 1'b1;
        if (valid_i) begin
          case (cmd_i)
            cmd_encrypt: begin
              state_d        = st_encrypt;
              ctrl_o.data_en = 1'b1;
              ctrl_o.key_en  = 1'b1;
            end
            cmd_load_shadow: begin
              // chained mode keeps the last cipher result
              if (mode_q == mode_chained) begin
                ctrl_o.shadow_copy = 1'b1;
              end else begin
                ctrl_o.shadow_load = 1'b1;
              end
            end
            cmd_digest_init: begin
              mode_d             = mode_i;
              ctrl_o.digest_init = 1'b1;
              ctrl_o.digest_en   = 1'b1;
            end
            cmd_digest: begin
              state_d         = st_digest;
              ctrl_o.data_sel = data_sel_digest;
              ctrl_o.key_sel  = (mode_q == mode_chained) ? key_sel_msg_chained
                                                         : key_sel_msg_input;
              ctrl_o.data_en  = 1'b1;
              ctrl_o.key_en   = 1'b1;
            end
            cmd_digest_final: begin
              state_d         = st_digest;
              ctrl_o.data_sel = data_sel_digest;
              ctrl_o.key_sel  = key_sel_const;
              ctrl_o.data_en  = 1'b1;
              ctrl_o.key_en   = 1'b1;
              // digest closed, fall back to standard mode
              mode_d          = mode_standard;
            end
            default: begin
              // unknown codes are dropped
              state_d = st_idle;
            end
          endcase
        end
      end
      ////////////////////////////////////////
      // plain encryption rounds
      st_encrypt: begin
        ctrl_o.data_sel = data_sel_round;
        ctrl_o.key_sel  = key_sel_round;
        ctrl_o.data_en  = 1'b1;
        ctrl_o.key_en   = 1'b1;
        if (last_rnd) begin
          state_d        = st_idle;
          ctrl_o.valid_d = 1'b1;
        end
      end
      ////////////////////////////////////////
      // digest rounds, Davies-Meyer feed-forward at the end
      st_digest: begin
        ctrl_o.data_sel = data_sel_round;
        ctrl_o.key_sel  = key_sel_round;
        ctrl_o.data_en  = 1'b1;
        ctrl_o.key_en   = 1'b1;
        if (last_rnd) begin
          state_d          = st_idle;
          ctrl_o.valid_d   = 1'b1;
          ctrl_o.data_sel  = data_sel_round_xor;
          // separate digest state survives interleaved encrypts
          ctrl_o.digest_en = 1'b1;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      mode_q  <= mode_standard;
    end else begin
      state_q <= state_d;
      mode_q  <= mode_d;
    end
  end

endmodule

//--- design/present_round.sv
/*
  One round of PRESENT-128 encryption together with one step of the
  128-bit key schedule. Purely combinational, meant to be iterated
  once per cycle around the working registers.
*/

`timescale 1ns/10ps

module present_round (
  input  logic [scrmbl_pkg::block_width-1:0] data_i,
  input  scrmbl_pkg::key_msg_u               key_i,
  input  logic [scrmbl_pkg::cnt_width-1:0]   idx_i,
  output logic [scrmbl_pkg::block_width-1:0] data_o,
  output scrmbl_pkg::key_msg_u               key_o,
  output logic [scrmbl_pkg::cnt_width-1:0]   idx_o
);

  import scrmbl_pkg::*;

  logic [block_width-1:0] add_key;
  logic [block_width-1:0] sub_data;
  logic [block_width-1:0] perm_data;
  logic [key_width-1:0]   key_next;
  logic                   last_rnd;

  ////////////////////////////////////////
  // data path
  ////////////////////////////////////////

  // round key is the top half of the key register
  assign add_key = data_i ^ key_i.key[key_width-1 -: block_width];

  // sbox layer, one lookup per nibble
  always_comb begin
    for (int n = 0; n < block_width / 4; n++) begin
      sub_data[4*n +: 4] = present_sbox[add_key[4*n +: 4]];
    end
  end

  // bit i moves to 16*i mod 63, the top bit stays in place
  always_comb begin
    for (int i = 0; i < block_width - 1; i++) begin
      perm_data[(i * (block_width / 4)) % (block_width - 1)] = sub_data[i];
    end
    perm_data[block_width-1] = sub_data[block_width-1];
  end

  ////////////////////////////////////////
  // key schedule
  ////////////////////////////////////////

  always_comb begin
    // rotate left by 61
    key_next = {key_i.key[66:0], key_i.key[127:67]};
    // top two nibbles through the sbox
    key_next[127:124] = present_sbox[key_next[127:124]];
    key_next[123:120] = present_sbox[key_next[123:120]];
    // round counter mixed into bits 66..62
    key_next[66:62] = key_next[66:62] ^ idx_i;
  end

  assign key_o.key = key_next;
  assign idx_o     = idx_i + cnt_width'(1);

  // after the last round the next round key whitens the output
  assign last_rnd = (idx_i == cnt_width'(num_rounds));
  assign data_o   = last_rnd ? (perm_data ^ key_next[key_width-1 -: block_width]) : perm_data;

endmodule

//--- design/scrmbl_pkg.sv
/*
  Shared widths, command codes, constant tables and types for the
  OTP scrambling engine. Every design file imports this package.
*/

package scrmbl_pkg;

  ////////////////////////////////////////
  // widths and counts
  ////////////////////////////////////////

  localparam int unsigned block_width     = 64;
  localparam int unsigned key_width       = 128;
  localparam int unsigned num_rounds      = 31;
  localparam int unsigned cnt_width       = 5;
  localparam int unsigned num_keys        = 4;
  localparam int unsigned num_digest_sets = 2;
  localparam int unsigned sel_width       = 2;

  ////////////////////////////////////////
  // constant tables
  ////////////////////////////////////////

  // PRESENT 4-bit S-box, entry 15 listed first
  localparam logic [15:0][3:0] present_sbox = {
    4'h2, 4'h1, 4'h7, 4'h4, 4'h8, 4'hf, 4'he, 4'h3,
    4'hd, 4'ha, 4'h0, 4'h9, 4'hb, 4'h6, 4'h5, 4'hc
  };

  // scrambling keys, entry 0 all zeros for the known-answer vector
  localparam logic [num_keys-1:0][key_width-1:0] scrmbl_key_tbl = {
    128'h3ba1_7c59_e04d_826f_19c7_a3e2_5d80_b46e,
    128'hd42f_6e93_07b8_c15a_8e21_f937_4ac6_0d5b,
    128'h7f05_b2c8_91e3_46da_2b6c_d058_e19f_73a4,
    128'h0
  };

  // initialization vectors for the digest state
  localparam logic [num_digest_sets-1:0][block_width-1:0] digest_iv_tbl = {
    64'h91b4_2ed7_0c63_f85a,
    64'h5a1f_c730_8e26_4db9
  };

  // finalization constants, used as cipher key on the digest state
  localparam logic [num_digest_sets-1:0][key_width-1:0] digest_const_tbl = {
    128'he6c2_0a4f_93b7_5d18_27f0_c9e4_6b31_a85d,
    128'h4d8a_f153_2b6e_097c_d3a5_18f6_e027_bc94
  };

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    cmd_encrypt      = 3'd0,
    cmd_load_shadow  = 3'd1,
    cmd_digest_init  = 3'd2,
    cmd_digest       = 3'd3,
    cmd_digest_final = 3'd4
  } scrmbl_cmd_e;

  typedef enum logic {
    mode_standard = 1'b0,
    mode_chained  = 1'b1
  } digest_mode_e;

  // request word from the outside
  typedef struct packed {
    scrmbl_cmd_e            cmd;
    digest_mode_e           mode;
    logic [sel_width-1:0]   sel;
    logic [block_width-1:0] data;
  } scrmbl_req_t;

  // key register seen as a cipher key or as a 128-bit digest message
  typedef union packed {
    logic [key_width-1:0] key;
    struct packed {
      logic [block_width-1:0] hi;
      logic [block_width-1:0] lo;
    } msg;
  } key_msg_u;

  typedef enum logic [1:0] {
    data_sel_input     = 2'd0,
    data_sel_round     = 2'd1,
    data_sel_digest    = 2'd2,
    data_sel_round_xor = 2'd3
  } data_sel_e;

  typedef enum logic [2:0] {
    key_sel_round       = 3'd0,
    key_sel_table       = 3'd1,
    key_sel_const       = 3'd2,
    key_sel_msg_input   = 3'd3,
    key_sel_msg_chained = 3'd4
  } key_sel_e;

  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_encrypt = 2'd1,
    st_digest  = 2'd2
  } seq_state_e;

  // register controls from the sequencer
  typedef struct packed {
    data_sel_e data_sel;
    key_sel_e  key_sel;
    logic      data_en;
    logic      key_en;
    logic      shadow_copy;
    logic      shadow_load;
    logic      digest_en;
    logic      digest_init;
    logic      valid_d;
  } reg_ctrl_t;

endpackage
